//--- bht.sv
`timescale 1ns/1ps
`default_nettype none

module bht (
	input  wire        clk,
	input  wire        rst_n_i,
	input  wire [31:0] lookup_pc_i,
	output logic       predict_taken_o,
	input  wire        update_i,
	input  wire [31:0] update_pc_i,
	input  wire        update_taken_i
);

	import bpu_pkg::*;

	logic [1:0]           counter_q [BHT_ENTRIES];
	logic [BHT_IDX_W-1:0] lookup_idx;
	logic [BHT_IDX_W-1:0] update_idx;
	logic [1:0]           next_cnt;

	assign lookup_idx = lookup_pc_i[BHT_IDX_W+1:2];
	assign update_idx = update_pc_i[BHT_IDX_W+1:2];

	// Counter MSB gives the direction
	assign predict_taken_o = counter_q[lookup_idx][1];

	// Saturating step toward the resolved direction
	always_comb begin
		next_cnt = counter_q[update_idx];
		if (update_taken_i && next_cnt != 2'b11) begin
			next_cnt = next_cnt + 2'd1;
		end else if (!update_taken_i && next_cnt != 2'b00) begin
			next_cnt = next_cnt - 2'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			// weakly not taken
			for (int i = 0; i < BHT_ENTRIES; i++) begin
				counter_q[i] <= 2'b01;
			end
		end else if (update_i) begin
			counter_q[update_idx] <= next_cnt;
		end
	end

endmodule : bht

`default_nettype wire

//--- bpf.sv
`timescale 1ns/1ps
`default_nettype none

module bpf (
	input  wire                        resolve_valid_i,
	input  wire [31:0]                 resolve_pc_i,
	input  wire [31:0]                 rj_data_i,
	input  wire [31:0]                 rd_data_i,
	input  wire [31:0]                 resolve_npc_i,
	input  wire bpu_pkg::branch_kind_e kind_i,
	input  wire bpu_pkg::cmp_kind_e    cmp_i,
	input  wire                        link_i,
	input  wire [4:0]                  rj_idx_i,
	input  wire [4:0]                  rd_idx_i,
	input  wire [31:0]                 offs26_i,
	input  wire [31:0]                 offs16_i,
	output logic                       flush_o,
	output logic [31:0]                redirect_pc_o,
	output logic                       taken_o,
	output bpu_pkg::branch_class_e     class_o,
	output logic                       bht_update_o,
	output logic                       btb_update_o,
	output logic                       ras_push_o,
	output logic                       ras_pop_o
);

	import bpu_pkg::*;

	logic [31:0] seq_pc;
	logic        cmp_taken;

	assign seq_pc = resolve_pc_i + 32'd4;

	// -------------------------------------------------------------------------
	// Direction and target
	// -------------------------------------------------------------------------
	always_comb begin
		case (cmp_i)
			CMP_EQ:  cmp_taken = (rj_data_i == rd_data_i);
			CMP_NE:  cmp_taken = (rj_data_i != rd_data_i);
			CMP_LT:  cmp_taken = ($signed(rj_data_i) < $signed(rd_data_i));
			CMP_GE:  cmp_taken = ($signed(rj_data_i) >= $signed(rd_data_i));
			CMP_LTU: cmp_taken = (rj_data_i < rd_data_i);
			CMP_GEU: cmp_taken = (rj_data_i >= rd_data_i);
			default: cmp_taken = 1'b0;
		endcase
	end

	// Unconditional kinds always taken
	assign taken_o = (kind_i == BR_CONDITION) ? cmp_taken : (kind_i != BR_NONE);

	always_comb begin
		case (kind_i)
			BR_IMMEDIATE: redirect_pc_o = resolve_pc_i + (offs26_i << 2);
			BR_INDIRECT:  redirect_pc_o = rj_data_i + (offs16_i << 2);
			BR_CONDITION: redirect_pc_o = cmp_taken ? resolve_pc_i + (offs16_i << 2) : seq_pc;
			default:      redirect_pc_o = seq_pc;
		endcase
	end

	// -------------------------------------------------------------------------
	// Classification, call takes priority over return
	// -------------------------------------------------------------------------
	always_comb begin
		if (link_i || (kind_i == BR_INDIRECT && rd_idx_i == 5'd1)) begin
			class_o = CLS_CALL;
		end else if (kind_i == BR_INDIRECT && rj_idx_i == 5'd1 && offs16_i == '0) begin
			class_o = CLS_RETURN;
		end else if (kind_i == BR_IMMEDIATE || kind_i == BR_INDIRECT) begin
			class_o = CLS_ABSOLUTE;
		end else begin
			class_o = CLS_PC_RELATIVE;
		end
	end

	// Carried prediction disagrees with the real next PC
	assign flush_o = resolve_valid_i && (resolve_npc_i != redirect_pc_o);

	// Table strobes, already qualified by the resolve strobe
	assign bht_update_o = resolve_valid_i && (kind_i == BR_CONDITION);
	assign btb_update_o = flush_o && taken_o;
	assign ras_push_o   = resolve_valid_i && (class_o == CLS_CALL);
	assign ras_pop_o    = resolve_valid_i && (class_o == CLS_RETURN);

endmodule : bpf

`default_nettype wire

//--- bpu.f
bpu_pkg.sv
branch_decode.sv
bpf.sv
bht.sv
btb.sv
ras.sv
next_pc_select.sv
bpu_top.sv
bpu_properties.sv
bpu_tb.sv

//--- bpu_pkg.sv
`default_nettype none

package bpu_pkg;

	// -------------------------------------------------------------------------
	// Table geometry
	// -------------------------------------------------------------------------

	// Word PC, byte offset bits dropped
	localparam int PC_W        = 30;

	// BHT indexed by pc[7:2]
	localparam int BHT_ENTRIES = 64;
	localparam int BHT_IDX_W   = 6;

	// BTB indexed by pc[6:2], tagged by pc[31:7]
	localparam int BTB_ENTRIES = 32;
	localparam int BTB_IDX_W   = 5;
	localparam int BTB_TAG_W   = 25;

	localparam int RAS_DEPTH   = 8;
	localparam int RAS_PTR_W   = 3;

	// -------------------------------------------------------------------------
	// Branch opcodes, inst[31:26]
	// -------------------------------------------------------------------------
	localparam logic [5:0] OPC_JIRL = 6'h13;
	localparam logic [5:0] OPC_B    = 6'h14;
	localparam logic [5:0] OPC_BL   = 6'h15;
	localparam logic [5:0] OPC_BEQ  = 6'h16;
	localparam logic [5:0] OPC_BNE  = 6'h17;
	localparam logic [5:0] OPC_BLT  = 6'h18;
	localparam logic [5:0] OPC_BGE  = 6'h19;
	localparam logic [5:0] OPC_BLTU = 6'h1a;
	localparam logic [5:0] OPC_BGEU = 6'h1b;

	typedef enum logic [1:0] {BR_NONE, BR_IMMEDIATE, BR_INDIRECT, BR_CONDITION} branch_kind_e;

	typedef enum logic [2:0] {
		CMP_EQ, CMP_NE, CMP_LT, CMP_GE, CMP_LTU, CMP_GEU, CMP_NONE
	} cmp_kind_e;

	typedef enum logic [1:0] {CLS_PC_RELATIVE, CLS_ABSOLUTE, CLS_CALL, CLS_RETURN} branch_class_e;

	// b and bl, offset split in two fields
	typedef struct packed {
		logic [5:0]  opcode;
		logic [15:0] offs_lo;
		logic [9:0]  offs_hi;
	} inst_off26_t;

	// jirl and conditional branches
	typedef struct packed {
		logic [5:0]  opcode;
		logic [15:0] offs16;
		logic [4:0]  rj;
		logic [4:0]  rd;
	} inst_reg_t;

	typedef union packed {
		inst_off26_t off26;
		inst_reg_t   regs;
	} inst_word_u;

endpackage : bpu_pkg

`default_nettype wire

//--- bpu_properties.sv
`timescale 1ns/1ps
`default_nettype none

module bpu_properties (
	input wire        clk,
	input wire        rst_n_i,
	input wire        resolve_valid_i,
	input wire        flush_i,
	input wire [31:0] redirect_pc_i,
	input wire [31:0] predict_npc_i
);

	// A flush only comes from a resolved instruction
	flush_needs_resolve: assert property (@(posedge clk) disable iff (!rst_n_i)
		flush_i |-> resolve_valid_i)
		else $error("flush_o raised without resolve_valid_i");

	// Redirect must land on a word boundary
	flush_target_aligned: assert property (@(posedge clk) disable iff (!rst_n_i)
		flush_i |-> (redirect_pc_i[1:0] == 2'b00))
		else $error("redirect_pc_o not word aligned during a flush");

	npc_aligned: assert property (@(posedge clk) disable iff (!rst_n_i)
		predict_npc_i[1:0] == 2'b00)
		else $error("predict_npc_o not word aligned");

endmodule : bpu_properties

bind bpu_top bpu_properties u_properties (
	.clk(clk),
	.rst_n_i(rst_n_i),
	.resolve_valid_i(resolve_valid_i),
	.flush_i(flush_o),
	.redirect_pc_i(redirect_pc_o),
	.predict_npc_i(predict_npc_o)
);

`default_nettype wire

//--- bpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module bpu_tb;

	import bpu_pkg::*;

	// Reset, cold fetch, compares, b/bl/jirl, training, call and return
	localparam int TEST_CYCLES = 4 + 16 + 6 * 8 + 18 + 8 + 4 + 2 * (RAS_DEPTH + 3) + 1;

	logic        clk = 1'b0;
	logic        rst_n_i;
	logic        fetch_valid_i;
	logic        resolve_valid_i;
	logic [31:0] fetch_pc_i;
	logic [31:0] resolve_pc_i;
	logic [31:0] resolve_inst_i;
	logic [31:0] rj_data_i;
	logic [31:0] rd_data_i;
	logic [31:0] resolve_npc_i;
	wire  [31:0] predict_npc_o;
	wire  [31:0] redirect_pc_o;
	wire         flush_o;
	integer      seed = 59;
	int          error_count = 0;

	// Shadow BHT, BTB and RAS
	logic [1:0]    m_bht [BHT_ENTRIES];
	logic          m_btb_vld [BTB_ENTRIES];
	logic [31:0]   m_btb_pc [BTB_ENTRIES];
	logic [31:0]   m_btb_tgt [BTB_ENTRIES];
	branch_class_e m_btb_cls [BTB_ENTRIES];
	logic [31:0]   m_ras [$];

	bpu_top dut (.*);

	always #20 clk = ~clk;

	initial begin
		#((TEST_CYCLES + 20) * 40);
		$display("Watchdog expired, the run did not finish in time");
		$display("RESULT: FAIL");
		$fatal(1, "timeout");
	end

	// -------------------------------------------------------------------------
	// Reference model
	// -------------------------------------------------------------------------
	function automatic logic [31:0] ref_predict(input logic [31:0] pc);
		int ti;
		ti = pc[6:2];
		ref_predict = pc + 32'd4;
		if (m_btb_vld[ti] && m_btb_pc[ti][31:7] == pc[31:7]) begin
			case (m_btb_cls[ti])
				CLS_RETURN: if (m_ras.size() > 0) ref_predict = m_ras[$];
				CLS_CALL, CLS_ABSOLUTE: ref_predict = m_btb_tgt[ti];
				default: if (m_bht[pc[7:2]][1]) ref_predict = m_btb_tgt[ti];
			endcase
		end
	endfunction

	function automatic void ref_resolve(input logic [31:0] pc, input logic [31:0] inst,
		input logic [31:0] rj, input logic [31:0] rd, output logic [31:0] tgt,
		output logic tkn, output branch_class_e cls);
		logic [5:0]  opc;
		logic [31:0] o16;
		logic [31:0] o26;
		opc = inst[31:26];
		o16 = {{16{inst[25]}}, inst[25:10]};
		// High offset field lives in the low instruction bits
		o26 = {{6{inst[9]}}, inst[9:0], inst[25:10]};
		tkn = 1'b1;
		tgt = pc + 32'd4;
		case (opc)
			OPC_B, OPC_BL: tgt = pc + (o26 << 2);
			OPC_JIRL:      tgt = rj + (o16 << 2);
			OPC_BEQ:       tkn = (rj == rd);
			OPC_BNE:       tkn = (rj != rd);
			OPC_BLT:       tkn = ($signed(rj) < $signed(rd));
			OPC_BGE:       tkn = ($signed(rj) >= $signed(rd));
			OPC_BLTU:      tkn = (rj < rd);
			OPC_BGEU:      tkn = (rj >= rd);
			default:       tkn = 1'b0;
		endcase
		if (tkn && opc >= OPC_BEQ && opc <= OPC_BGEU) tgt = pc + (o16 << 2);
		if (opc == OPC_BL || (opc == OPC_JIRL && inst[4:0] == 5'd1)) cls = CLS_CALL;
		else if (opc == OPC_JIRL && inst[9:5] == 5'd1 && inst[25:10] == '0) cls = CLS_RETURN;
		else if (opc == OPC_B || opc == OPC_JIRL) cls = CLS_ABSOLUTE;
		else cls = CLS_PC_RELATIVE;
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		error_count++;
		$display("[ERROR] t=%0t %s expected %h actual %h", $time, name, exp, act);
		$display("RESULT: FAIL");
		$fatal(1, "mismatch on %s", name);
	endtask

	// One cycle of fetch and resolve, checked and then applied to the model
	task automatic drive_and_check(input logic [31:0] fpc, input logic rv,
		input logic [31:0] rpc, input logic [31:0] inst, input logic [31:0] rj,
		input logic [31:0] rd, input logic [31:0] npc);
		logic [31:0]   tgt;
		logic [31:0]   exp_npc;
		logic          tkn;
		logic          exp_flush;
		branch_class_e cls;
		int            bi;
		int            ti;
		@(posedge clk);
		#2;
		fetch_valid_i = 1'b1;
		fetch_pc_i = fpc;
		resolve_valid_i = rv;
		resolve_pc_i = rpc;
		resolve_inst_i = inst;
		rj_data_i = rj;
		rd_data_i = rd;
		resolve_npc_i = npc;
		exp_npc = ref_predict(fpc);
		ref_resolve(rpc, inst, rj, rd, tgt, tkn, cls);
		exp_flush = rv && (npc != tgt);
		#10;
		chk_npc: assert (predict_npc_o === exp_npc)
			else report_mismatch("predict_npc_o", exp_npc, predict_npc_o);
		chk_flush: assert (flush_o === exp_flush)
			else report_mismatch("flush_o", 32'(exp_flush), 32'(flush_o));
		chk_redirect: assert (!rv || redirect_pc_o === tgt)
			else report_mismatch("redirect_pc_o", tgt, redirect_pc_o);
		bi = rpc[7:2];
		ti = rpc[6:2];
		if (rv && inst[31:26] >= OPC_BEQ && inst[31:26] <= OPC_BGEU) begin
			if (tkn && m_bht[bi] != 2'b11) m_bht[bi]++;
			else if (!tkn && m_bht[bi] != 2'b00) m_bht[bi]--;
		end
		if (exp_flush && tkn) begin
			m_btb_vld[ti] = 1'b1;
			m_btb_pc[ti] = rpc;
			m_btb_tgt[ti] = tgt;
			m_btb_cls[ti] = cls;
		end
		// Oldest return address drops out past the stack depth
		if (rv && cls == CLS_CALL) begin
			m_ras.push_back(rpc + 32'd4);
			if (m_ras.size() > RAS_DEPTH) void'(m_ras.pop_front());
		end else if (rv && cls == CLS_RETURN && m_ras.size() > 0) begin
			void'(m_ras.pop_back());
		end
	endtask

	// -------------------------------------------------------------------------
	// Stimulus
	// -------------------------------------------------------------------------
	initial begin
		logic [31:0] pc;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] tgt;
		logic [31:0] inst;
		logic [31:0] call_inst;
		logic [31:0] ret_inst;
		logic        tkn;
		branch_class_e cls;
		rst_n_i = 1'b0;
		fetch_valid_i = 1'b0;
		fetch_pc_i = '0;
		resolve_valid_i = 1'b0;
		resolve_pc_i = '0;
		resolve_inst_i = '0;
		rj_data_i = '0;
		rd_data_i = '0;
		resolve_npc_i = '0;
		for (int i = 0; i < BHT_ENTRIES; i++) m_bht[i] = 2'b01;
		for (int i = 0; i < BTB_ENTRIES; i++) m_btb_vld[i] = 1'b0;
		repeat (4) @(posedge clk);
		#2 rst_n_i = 1'b1;

		// Cold tables and non-branch resolves
		repeat (16) begin
			pc = $random(seed) & 32'hffff_fffc;
			drive_and_check(pc, 1'b1, pc, {6'h00, 26'($random(seed))}, 0, 0, pc + 4);
		end
		// All six compares, equal operands half the time
		for (int k = 0; k < 6; k++) begin
			repeat (8) begin
				pc = $random(seed) & 32'hffff_fffc;
				a = $random(seed);
				b = ($random(seed) & 1) ? a : $random(seed);
				inst = {OPC_BEQ + 6'(k), 16'($random(seed)), 10'($random(seed))};
				drive_and_check(pc, 1'b1, pc, inst, a, b, pc + 4);
			end
		end
		// jirl, b and bl, every other one carries a wrong next PC
		for (int k = 0; k < 18; k++) begin
			pc = $random(seed) & 32'hffff_fffc;
			a = $random(seed) & 32'hffff_fffc;
			inst = {OPC_JIRL + 6'(k % 3), 26'($random(seed))};
			ref_resolve(pc, inst, a, 0, tgt, tkn, cls);
			drive_and_check(pc, 1'b1, pc, inst, a, 0, (k % 2) ? tgt + 8 : tgt);
		end
		// Train a taken beq, then walk it back to not taken
		pc = 32'h0000_1040;
		inst = {OPC_BEQ, 16'h0010, 10'h000};
		repeat (3) drive_and_check(pc, 1'b1, pc, inst, 32'h5, 32'h5, pc + 4);
		drive_and_check(pc, 1'b0, pc, inst, 0, 0, 0);
		repeat (3) drive_and_check(pc, 1'b1, pc, inst, 32'h5, 32'h6, ref_predict(pc));
		drive_and_check(pc, 1'b0, pc, inst, 0, 0, 0);
		// Call, mispredicted return, second call, then fetch of the return
		// Return sits in an odd BTB slot, apart from every call site
		a = 32'h0000_2000;
		pc = 32'h0000_3004;
		call_inst = {OPC_BL, 16'h0100, 10'h000};
		ret_inst = {OPC_JIRL, 16'h0000, 5'd1, 5'd0};
		drive_and_check(a, 1'b1, a, call_inst, 0, 0, ref_predict(a));
		drive_and_check(pc, 1'b1, pc, ret_inst, a + 4, 0, pc + 4);
		drive_and_check(a, 1'b1, a, call_inst, 0, 0, ref_predict(a));
		drive_and_check(pc, 1'b0, pc, ret_inst, 0, 0, 0);
		// Nesting past the stack depth
		for (int k = 0; k < RAS_DEPTH + 3; k++) begin
			a = 32'h0001_0000 + 32'(k) * 8;
			drive_and_check(a, 1'b1, a, call_inst, 0, 0, ref_predict(a));
		end
		repeat (RAS_DEPTH + 3) begin
			b = (m_ras.size() > 0) ? m_ras[$] : 32'h0;
			drive_and_check(pc, 1'b1, pc, ret_inst, b, 0, ref_predict(pc));
		end
		drive_and_check(pc, 1'b0, pc, ret_inst, 0, 0, 0);

		if (error_count == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule : bpu_tb

`default_nettype wire

//--- bpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module bpu_top (
	input  wire         clk,
	input  wire         rst_n_i,
	input  wire         fetch_valid_i,
	input  wire  [31:0] fetch_pc_i,
	output logic [31:0] predict_npc_o,
	input  wire         resolve_valid_i,
	input  wire  [31:0] resolve_pc_i,
	input  wire  [31:0] resolve_inst_i,
	input  wire  [31:0] rj_data_i,
	input  wire  [31:0] rd_data_i,
	input  wire  [31:0] resolve_npc_i,
	output logic        flush_o,
	output logic [31:0] redirect_pc_o
);

	import bpu_pkg::*;

	// Decode to feedback
	branch_kind_e    dec_kind;
	cmp_kind_e       dec_cmp;
	logic            dec_link;
	logic [4:0]      dec_rj_idx;
	logic [4:0]      dec_rd_idx;
	logic [31:0]     dec_offs26;
	logic [31:0]     dec_offs16;

	// Feedback to tables
	logic            taken;
	branch_class_e   cls;
	logic            bht_update;
	logic            btb_update;
	logic            ras_push;
	logic            ras_pop;

	// Table lookups
	logic            bht_taken;
	logic            btb_hit;
	logic [PC_W-1:0] btb_target;
	branch_class_e   btb_class;
	logic [PC_W-1:0] ras_top;
	logic            ras_empty;

	// -------------------------------------------------------------------------
	// Resolve side
	// -------------------------------------------------------------------------
	branch_decode u_decode (.resolve_inst_i(resolve_inst_i), .kind_o(dec_kind),
		.cmp_o(dec_cmp), .link_o(dec_link), .rj_idx_o(dec_rj_idx), .rd_idx_o(dec_rd_idx),
		.offs26_o(dec_offs26), .offs16_o(dec_offs16));

	bpf u_bpf (.resolve_valid_i(resolve_valid_i), .resolve_pc_i(resolve_pc_i),
		.rj_data_i(rj_data_i), .rd_data_i(rd_data_i), .resolve_npc_i(resolve_npc_i),
		.kind_i(dec_kind), .cmp_i(dec_cmp), .link_i(dec_link), .rj_idx_i(dec_rj_idx),
		.rd_idx_i(dec_rd_idx), .offs26_i(dec_offs26), .offs16_i(dec_offs16),
		.flush_o(flush_o), .redirect_pc_o(redirect_pc_o), .taken_o(taken), .class_o(cls),
		.bht_update_o(bht_update), .btb_update_o(btb_update), .ras_push_o(ras_push),
		.ras_pop_o(ras_pop));

	// -------------------------------------------------------------------------
	// Tables, looked up by fetch and trained by resolve
	// -------------------------------------------------------------------------
	bht u_bht (.clk(clk), .rst_n_i(rst_n_i), .lookup_pc_i(fetch_pc_i),
		.predict_taken_o(bht_taken), .update_i(bht_update), .update_pc_i(resolve_pc_i),
		.update_taken_i(taken));

	btb u_btb (.clk(clk), .rst_n_i(rst_n_i), .lookup_pc_i(fetch_pc_i), .hit_o(btb_hit),
		.target_o(btb_target), .class_o(btb_class), .write_i(btb_update),
		.write_pc_i(resolve_pc_i), .write_target_i(redirect_pc_o), .write_class_i(cls));

	// Return address derived inside from the call PC
	ras u_ras (.clk(clk), .rst_n_i(rst_n_i), .push_i(ras_push),
		.push_addr_i(resolve_pc_i[31:2]), .pop_i(ras_pop), .top_o(ras_top),
		.empty_o(ras_empty));

	next_pc_select u_npc (.fetch_valid_i(fetch_valid_i), .fetch_pc_i(fetch_pc_i),
		.bht_taken_i(bht_taken), .btb_hit_i(btb_hit), .btb_target_i(btb_target),
		.btb_class_i(btb_class), .ras_top_i(ras_top), .ras_empty_i(ras_empty),
		.predict_npc_o(predict_npc_o));

endmodule : bpu_top

`default_nettype wire

//--- branch_decode.sv
`timescale 1ns/1ps
`default_nettype none

module branch_decode (
	input  wire bpu_pkg::inst_word_u resolve_inst_i,
	output bpu_pkg::branch_kind_e    kind_o,
	output bpu_pkg::cmp_kind_e       cmp_o,
	output logic                     link_o,
	output logic [4:0]               rj_idx_o,
	output logic [4:0]               rd_idx_o,
	output logic [31:0]              offs26_o,
	output logic [31:0]              offs16_o
);

	import bpu_pkg::*;

	logic [5:0]  opcode;
	logic [25:0] offs26;

	// Opcode and register fields from the register view
	assign opcode   = resolve_inst_i.regs.opcode;
	assign rj_idx_o = resolve_inst_i.regs.rj;
	assign rd_idx_o = resolve_inst_i.regs.rd;
	assign offs16_o = {{16{resolve_inst_i.regs.offs16[15]}}, resolve_inst_i.regs.offs16};

	// Upper ten offset bits sit in the low instruction bits
	assign offs26   = {resolve_inst_i.off26.offs_hi, resolve_inst_i.off26.offs_lo};
	assign offs26_o = {{6{offs26[25]}}, offs26};

	always_comb begin
		kind_o = BR_CONDITION;
		cmp_o  = CMP_NONE;
		link_o = 1'b0;
		case (opcode)
			OPC_JIRL: kind_o = BR_INDIRECT;
			OPC_B:    kind_o = BR_IMMEDIATE;
			OPC_BL: begin
				kind_o = BR_IMMEDIATE;
				link_o = 1'b1;
			end
			OPC_BEQ:  cmp_o = CMP_EQ;
			OPC_BNE:  cmp_o = CMP_NE;
			OPC_BLT:  cmp_o = CMP_LT;
			OPC_BGE:  cmp_o = CMP_GE;
			OPC_BLTU: cmp_o = CMP_LTU;
			OPC_BGEU: cmp_o = CMP_GEU;
			// Not a branch
			default:  kind_o = BR_NONE;
		endcase
	end

endmodule : branch_decode

`default_nettype wire

//--- btb.sv
`timescale 1ns/1ps
`default_nettype none

module btb (
	input  wire                         clk,
	input  wire                         rst_n_i,
	input  wire [31:0]                  lookup_pc_i,
	output logic                        hit_o,
	output logic [bpu_pkg::PC_W-1:0]    target_o,
	output bpu_pkg::branch_class_e      class_o,
	input  wire                         write_i,
	input  wire [31:0]                  write_pc_i,
	input  wire [31:0]                  write_target_i,
	input  wire bpu_pkg::branch_class_e write_class_i
);

	import bpu_pkg::*;

	logic                 valid_q  [BTB_ENTRIES];
	logic [BTB_TAG_W-1:0] tag_q    [BTB_ENTRIES];
	logic [PC_W-1:0]      target_q [BTB_ENTRIES];
	branch_class_e        class_q  [BTB_ENTRIES];

	logic [BTB_IDX_W-1:0] lookup_idx;
	logic [BTB_TAG_W-1:0] lookup_tag;
	logic [BTB_IDX_W-1:0] write_idx;
	logic [BTB_TAG_W-1:0] write_tag;

	// -------------------------------------------------------------------------
	// Lookup
	// -------------------------------------------------------------------------
	assign lookup_idx = lookup_pc_i[BTB_IDX_W+1:2];
	assign lookup_tag = lookup_pc_i[31 -: BTB_TAG_W];

	assign hit_o    = valid_q[lookup_idx] && (tag_q[lookup_idx] == lookup_tag);
	assign target_o = target_q[lookup_idx];
	assign class_o  = class_q[lookup_idx];

	// -------------------------------------------------------------------------
	// Write, direct mapped so the indexed entry is replaced
	// -------------------------------------------------------------------------
	assign write_idx = write_pc_i[BTB_IDX_W+1:2];
	assign write_tag = write_pc_i[31 -: BTB_TAG_W];

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			for (int i = 0; i < BTB_ENTRIES; i++) begin
				valid_q[i] <= 1'b0;
			end
		end else if (write_i) begin
			valid_q[write_idx] <= 1'b1;
		end
	end

	// Entry payload
	always_ff @(posedge clk) begin
		if (write_i) begin
			tag_q[write_idx]    <= write_tag;
			target_q[write_idx] <= write_target_i[31:2];
			class_q[write_idx]  <= write_class_i;
		end
	end

endmodule : btb

`default_nettype wire

//--- next_pc_select.sv
`timescale 1ns/1ps
`default_nettype none

module next_pc_select (
	input  wire                         fetch_valid_i,
	input  wire [31:0]                  fetch_pc_i,
	input  wire                         bht_taken_i,
	input  wire                         btb_hit_i,
	input  wire [bpu_pkg::PC_W-1:0]     btb_target_i,
	input  wire bpu_pkg::branch_class_e btb_class_i,
	input  wire [bpu_pkg::PC_W-1:0]     ras_top_i,
	input  wire                         ras_empty_i,
	output logic [31:0]                 predict_npc_o
);

	import bpu_pkg::*;

	logic [PC_W-1:0] seq_word;
	logic [PC_W-1:0] npc_word;

	assign seq_word = fetch_pc_i[31:2] + PC_W'(1);

	// Idle fetch falls through to the sequential PC
	always_comb begin
		npc_word = seq_word;
		if (fetch_valid_i && btb_hit_i) begin
			case (btb_class_i)
				CLS_RETURN: begin
					if (!ras_empty_i) begin
						npc_word = ras_top_i;
					end
				end
				CLS_CALL, CLS_ABSOLUTE: npc_word = btb_target_i;
				// conditional, follow the counter
				default: begin
					if (bht_taken_i) begin
						npc_word = btb_target_i;
					end
				end
			endcase
		end
	end

	assign predict_npc_o = {npc_word, 2'b00};

endmodule : next_pc_select

`default_nettype wire

//--- ras.sv
`timescale 1ns/1ps
`default_nettype none

module ras (
	input  wire                      clk,
	input  wire                      rst_n_i,
	input  wire                      push_i,
	input  wire [bpu_pkg::PC_W-1:0]  push_addr_i,
	input  wire                      pop_i,
	output logic [bpu_pkg::PC_W-1:0] top_o,
	output logic                     empty_o
);

	import bpu_pkg::*;

	logic [PC_W-1:0]      stack_q [RAS_DEPTH];
	logic [RAS_PTR_W-1:0] ptr_q;
	logic [RAS_PTR_W:0]   count_q;
	logic [RAS_PTR_W-1:0] top_idx;
	logic [PC_W-1:0]      ret_addr;

	// ptr_q is the next free slot, it wraps onto the oldest entry
	assign top_idx = ptr_q - 1'b1;
	assign top_o   = stack_q[top_idx];
	assign empty_o = (count_q == '0);

	// Call site in, return lands on the following word
	assign ret_addr = push_addr_i + PC_W'(1);

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			ptr_q   <= '0;
			count_q <= '0;
		end else if (push_i && !pop_i) begin
			ptr_q <= ptr_q + 1'b1;
			// Depth saturates, oldest entry lost
			if (count_q != (RAS_PTR_W+1)'(RAS_DEPTH)) begin
				count_q <= count_q + 1'b1;
			end
		end else if (pop_i && !push_i && !empty_o) begin
			ptr_q   <= top_idx;
			count_q <= count_q - 1'b1;
		end
	end

	// Push together with pop rewrites the top in place
	always_ff @(posedge clk) begin
		if (push_i) begin
			stack_q[pop_i ? top_idx : ptr_q] <= ret_addr;
		end
	end

endmodule : ras

`default_nettype wire
